//--- design/disp_cmd_pkg.sv
package disp_cmd_pkg;

    // one init word: flag in bit 15, byte in bits 7..0
    typedef struct packed {
        logic       flag;
        logic [6:0] rsvd;
        logic [7:0] data;
    } disp_word_t;

    // 26 register/value pairs
    localparam int init_len = 52;

    typedef logic [5:0] step_idx_t;

    // gap after a word, in units of gap_scale cycles
    typedef logic [7:0] gap_t;

    function automatic logic word_is_reg(disp_word_t w);
        return w.flag;
    endfunction

    // register address word (0x80 upper byte)
    function automatic disp_word_t reg_word(logic [7:0] b);
        return '{flag: 1'b1, rsvd: 7'h00, data: b};
    endfunction

    // data word for the last selected register
    function automatic disp_word_t data_word(logic [7:0] b);
        return '{flag: 1'b0, rsvd: 7'h00, data: b};
    endfunction

endpackage

//--- design/disp_bus_pkg.sv
package disp_bus_pkg;

    // write cycle phases of the 8080 bus writer
    typedef enum logic [1:0] {
        idle,
        setup,
        strobe,
        hold
    } bus_phase_t;

    // cs_n low to wr_n low
    localparam int setup_cyc_def = 2;

    // wr_n low width
    localparam int pulse_cyc_def = 3;

    // wr_n high to cs_n high
    localparam int hold_cyc_def = 2;

    // cycles per gap unit
    localparam int gap_scale_def = 4;

endpackage

//--- design/disp_init_rom.sv
module disp_init_rom import disp_cmd_pkg::*; (
    input  step_idx_t  step,
    output disp_word_t word,
    output gap_t       gap
);

    // about 130 cycles with the default gap unit
    localparam gap_t long_gap = 8'd32;

    always_comb begin
        case (step)
            6'd0:  word = reg_word(8'h00);
            6'd1:  word = data_word(8'h00);
            // PLL setup
            6'd2:  word = reg_word(8'h88);
            6'd3:  word = data_word(8'h0B);
            6'd4:  word = reg_word(8'h89);
            6'd5:  word = data_word(8'h02);
            // system and pixel clock
            6'd6:  word = reg_word(8'h10);
            6'd7:  word = data_word(8'h0C);
            6'd8:  word = reg_word(8'h04);
            6'd9:  word = data_word(8'h81);
            // horizontal timing
            6'd10: word = reg_word(8'h14);
            6'd11: word = data_word(8'h63);
            6'd12: word = reg_word(8'h15);
            6'd13: word = data_word(8'h00);
            6'd14: word = reg_word(8'h16);
            6'd15: word = data_word(8'h03);
            6'd16: word = reg_word(8'h17);
            6'd17: word = data_word(8'h03);
            6'd18: word = reg_word(8'h18);
            6'd19: word = data_word(8'h0B);
            // vertical timing
            6'd20: word = reg_word(8'h19);
            6'd21: word = data_word(8'hDF);
            6'd22: word = reg_word(8'h1A);
            6'd23: word = data_word(8'h01);
            6'd24: word = reg_word(8'h1B);
            6'd25: word = data_word(8'h1F);
            6'd26: word = reg_word(8'h1C);
            6'd27: word = data_word(8'h00);
            6'd28: word = reg_word(8'h1D);
            6'd29: word = data_word(8'h16);
            6'd30: word = reg_word(8'h1E);
            6'd31: word = data_word(8'h00);
            6'd32: word = reg_word(8'h1F);
            6'd33: word = data_word(8'h01);
            // active window
            6'd34: word = reg_word(8'h30);
            6'd35: word = data_word(8'h00);
            6'd36: word = reg_word(8'h31);
            6'd37: word = data_word(8'h00);
            6'd38: word = reg_word(8'h34);
            6'd39: word = data_word(8'h1F);
            6'd40: word = reg_word(8'h35);
            6'd41: word = data_word(8'h03);
            6'd42: word = reg_word(8'h32);
            6'd43: word = data_word(8'h00);
            6'd44: word = reg_word(8'h33);
            6'd45: word = data_word(8'h00);
            6'd46: word = reg_word(8'h36);
            6'd47: word = data_word(8'hDF);
            6'd48: word = reg_word(8'h37);
            6'd49: word = data_word(8'h01);
            // memory clear
            6'd50: word = reg_word(8'h8E);
            6'd51: word = data_word(8'h80);
            default: word = '0;
        endcase
    end

    // PLL needs time to lock after each PLL and clock-select write
    always_comb begin
        if (step >= step_idx_t'(init_len)) begin
            gap = '0;
        end else begin
            case (step)
                6'd3, 6'd5, 6'd9: gap = long_gap;
                default:          gap = 8'd1;
            endcase
        end
    end

endmodule

//--- design/disp_init_seq.sv
module disp_init_seq import disp_cmd_pkg::*; #(
    parameter int gap_scale = 1
) (
    input  logic       clk,
    input  logic       nrst,
    output step_idx_t  step,
    input  disp_word_t word,
    input  gap_t       gap,
    output logic       word_stb,
    output disp_word_t wr_word,
    input  logic       busy,
    output logic       done
);

    localparam int gcnt_w = $bits(gap_t) + $clog2(gap_scale + 1);

    typedef enum logic [1:0] {
        st_issue,
        st_wait_busy,
        st_gap,
        st_finished
    } seq_state_t;

    seq_state_t          state;
    logic [gcnt_w-1:0]   gap_cnt;
    logic                issue;

    assign issue = (state == st_issue) && !busy;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state    <= st_issue;
            step     <= '0;
            gap_cnt  <= '0;
            word_stb <= 1'b0;
            done     <= 1'b0;
        end else begin
            word_stb <= 1'b0;
            case (state)
                st_issue: begin
                    if (issue) begin
                        word_stb <= 1'b1;
                        state    <= st_wait_busy;
                    end
                end
                st_wait_busy: begin
                    // busy is not up yet in the strobe cycle
                    if (!word_stb && !busy) begin
                        gap_cnt <= gcnt_w'(gap) * gcnt_w'(gap_scale);
                        step    <= step + 1'b1;
                        if (step == step_idx_t'(init_len - 1)) begin
                            done  <= 1'b1;
                            state <= st_finished;
                        end else begin
                            state <= st_gap;
                        end
                    end
                end
                st_gap: begin
                    if (gap_cnt == '0) begin
                        state <= st_issue;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                default: state <= st_finished;
            endcase
        end
    end

    // stable copy for the writer
    always_ff @(posedge clk) begin
        if (issue) begin
            wr_word <= word;
        end
    end

    a_stb_not_busy: assert property (@(posedge clk) disable iff (!nrst)
        word_stb |-> !busy);

    a_step_range: assert property (@(posedge clk) disable iff (!nrst)
        !done |-> (step <= step_idx_t'(init_len)));

endmodule

//--- design/disp_bus_writer.sv
module disp_bus_writer import disp_cmd_pkg::*, disp_bus_pkg::*; #(
    parameter int setup_cyc = setup_cyc_def,
    parameter int pulse_cyc = pulse_cyc_def,
    parameter int hold_cyc  = hold_cyc_def
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       word_stb,
    input  disp_word_t wr_word,
    output logic       busy,
    output logic       cs_n,
    output logic       wr_n,
    output logic       rs,
    output logic [7:0] db
);

    localparam int max_sp  = (setup_cyc > pulse_cyc) ? setup_cyc : pulse_cyc;
    localparam int cnt_max = (max_sp > hold_cyc) ? max_sp : hold_cyc;
    localparam int cnt_w   = $clog2(cnt_max + 1);

    bus_phase_t       phase;
    logic [cnt_w-1:0] cnt;

    assign busy = (phase != idle);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            phase <= idle;
            cnt   <= '0;
            cs_n  <= 1'b1;
            wr_n  <= 1'b1;
            rs    <= 1'b0;
            db    <= '0;
        end else begin
            case (phase)
                idle: begin
                    if (word_stb) begin
                        phase <= setup;
                        cnt   <= cnt_w'(setup_cyc - 1);
                        cs_n  <= 1'b0;
                        // rs low selects a register address
                        rs    <= ~word_is_reg(wr_word);
                        db    <= wr_word.data;
                    end
                end
                setup: begin
                    if (cnt == '0) begin
                        phase <= strobe;
                        cnt   <= cnt_w'(pulse_cyc - 1);
                        wr_n  <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                strobe: begin
                    // panel latches db on the rising edge of wr_n
                    if (cnt == '0) begin
                        phase <= hold;
                        cnt   <= cnt_w'(hold_cyc - 1);
                        wr_n  <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    if (cnt == '0) begin
                        phase <= idle;
                        cs_n  <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    a_wr_in_cs: assert property (@(posedge clk) disable iff (!nrst)
        !wr_n |-> !cs_n);

    a_db_stable: assert property (@(posedge clk) disable iff (!nrst)
        (!cs_n && $past(!cs_n)) |-> ($stable(db) && $stable(rs)));

endmodule

//--- design/disp_init_top.sv
module disp_init_top import disp_cmd_pkg::*, disp_bus_pkg::*; #(
    parameter int setup_cyc = setup_cyc_def,
    parameter int pulse_cyc = pulse_cyc_def,
    parameter int hold_cyc  = hold_cyc_def,
    parameter int gap_scale = gap_scale_def
) (
    input  logic       clk,
    input  logic       nrst,
    output logic       cs_n,
    output logic       wr_n,
    output logic       rs,
    output logic [7:0] db,
    output logic       done
);

    step_idx_t  step;
    disp_word_t rom_word;
    gap_t       gap;
    logic       word_stb;
    disp_word_t wr_word;
    logic       busy;

    disp_init_seq #(
        .gap_scale(gap_scale)
    ) seq0 (
        .clk      (clk),
        .nrst     (nrst),
        .step     (step),
        .word     (rom_word),
        .gap      (gap),
        .word_stb (word_stb),
        .wr_word  (wr_word),
        .busy     (busy),
        .done     (done)
    );

    disp_init_rom rom0 (
        .step (step),
        .word (rom_word),
        .gap  (gap)
    );

    disp_bus_writer #(
        .setup_cyc(setup_cyc),
        .pulse_cyc(pulse_cyc),
        .hold_cyc (hold_cyc)
    ) wr0 (
        .clk      (clk),
        .nrst     (nrst),
        .word_stb (word_stb),
        .wr_word  (wr_word),
        .busy     (busy),
        .cs_n     (cs_n),
        .wr_n     (wr_n),
        .rs       (rs),
        .db       (db)
    );

endmodule

//--- sim/disp_tb_clk.sv
module disp_tb_clk #(
    parameter int period_ns = 40
) (
    output logic clk,
    output logic nrst,
    input  logic rst_req
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // power-on reset, then a 2-cycle pulse on each request
    initial begin
        nrst = 1'b0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        forever begin
            @(posedge clk);
            if (rst_req) begin
                nrst <= 1'b0;
                repeat (2) @(posedge clk);
                nrst <= 1'b1;
            end
        end
    end

endmodule

//--- sim/disp_init_tb.sv
module disp_init_tb import disp_cmd_pkg::*, disp_bus_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int setup_cyc = setup_cyc_def;
    localparam int pulse_cyc = pulse_cyc_def;
    localparam int hold_cyc  = hold_cyc_def;
    localparam int gap_scale = gap_scale_def;
    localparam int cs_cyc    = setup_cyc + pulse_cyc + hold_cyc;

    logic       clk;
    logic       nrst;
    logic       rst_req;
    logic       cs_n;
    logic       wr_n;
    logic       rs;
    logic [7:0] db;
    logic       done;

    int         err_cnt = 0;
    int         chk_cnt = 0;
    int         test_cnt = 0;
    int         n_words = 0;
    int         cyc = 0;
    int         cyc_limit = 0;
    logic       prev_cs = 1'b1;
    logic       prev_wr = 1'b1;
    int         cs_low = 0;
    int         wr_low = 0;
    int         idle = 0;
    disp_word_t hold_word;

    disp_tb_clk #(.period_ns(40)) clk0 (
        .clk     (clk),
        .nrst    (nrst),
        .rst_req (rst_req)
    );

    disp_init_top #(
        .setup_cyc(setup_cyc),
        .pulse_cyc(pulse_cyc),
        .hold_cyc (hold_cyc),
        .gap_scale(gap_scale)
    ) dut0 (
        .clk  (clk),
        .nrst (nrst),
        .cs_n (cs_n),
        .wr_n (wr_n),
        .rs   (rs),
        .db   (db),
        .done (done)
    );

    // reference init sequence, one register/value pair per two entries
    function automatic disp_word_t exp_word(int idx);
        logic [15:0] pair;
        disp_word_t  w;
        case (idx / 2)
            0:  pair = 16'h0000;
            1:  pair = 16'h880B;
            2:  pair = 16'h8902;
            3:  pair = 16'h100C;
            4:  pair = 16'h0481;
            5:  pair = 16'h1463;
            6:  pair = 16'h1500;
            7:  pair = 16'h1603;
            8:  pair = 16'h1703;
            9:  pair = 16'h180B;
            10: pair = 16'h19DF;
            11: pair = 16'h1A01;
            12: pair = 16'h1B1F;
            13: pair = 16'h1C00;
            14: pair = 16'h1D16;
            15: pair = 16'h1E00;
            16: pair = 16'h1F01;
            17: pair = 16'h3000;
            18: pair = 16'h3100;
            19: pair = 16'h341F;
            20: pair = 16'h3503;
            21: pair = 16'h3200;
            22: pair = 16'h3300;
            23: pair = 16'h36DF;
            24: pair = 16'h3701;
            25: pair = 16'h8E80;
            default: pair = 16'h0000;
        endcase
        w.flag = (idx % 2 == 0);
        w.rsvd = 7'h00;
        w.data = (idx % 2 == 0) ? pair[15:8] : pair[7:0];
        return w;
    endfunction

    // PLL lock time after the PLL and clock-select data words
    function automatic int exp_gap(int idx);
        if (idx == 3 || idx == 5 || idx == 9) begin
            return 32;
        end
        return 1;
    endfunction

    function automatic int gap_total();
        int sum;
        sum = 0;
        for (int i = 0; i < init_len; i++) begin
            sum += exp_gap(i) * gap_scale;
        end
        return sum;
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(string name, disp_word_t exp, disp_word_t act);
        chk_cnt++;
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        chk_cnt++;
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        chk_cnt++;
        if (act != exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic wait_for_done();
        @(posedge clk);
        while (!done) begin
            @(posedge clk);
        end
    endtask

    // bus monitor, sees the values from before each edge
    always @(posedge clk) begin
        disp_word_t bus_word;
        bus_word = '{flag: ~rs, rsvd: 7'h00, data: db};
        if (!nrst) begin
            n_words <= 0;
            prev_cs = 1'b1;
            prev_wr = 1'b1;
            cs_low = 0;
            wr_low = 0;
            idle = 0;
        end else begin
            if (n_words < init_len) begin
                check_bit("done", 1'b0, done);
            end
            if (!cs_n) begin
                if (prev_cs) begin
                    if (n_words > 0) begin
                        check_bit("idle >= gap", 1'b1,
                            logic'(idle >= exp_gap(n_words - 1) * gap_scale));
                    end
                    hold_word = bus_word;
                    idle = 0;
                end else begin
                    check_word("db/rs while cs_n low", hold_word, bus_word);
                end
                cs_low++;
            end else begin
                if (!prev_cs) begin
                    check_count("cs_n low cycles", cs_cyc, cs_low);
                    cs_low = 0;
                end
                idle++;
            end
            if (!wr_n) begin
                wr_low++;
            end else if (!prev_wr) begin
                check_count("wr_n low cycles", pulse_cyc, wr_low);
                wr_low = 0;
                if (n_words < init_len) begin
                    check_word("bus word", exp_word(n_words), bus_word);
                end else begin
                    $display("a write appeared after the end of the init table");
                    err_cnt++;
                end
                n_words <= n_words + 1;
            end
            prev_cs = cs_n;
            prev_wr = wr_n;
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc_limit > 0 && cyc >= cyc_limit) begin
            $display("timeout after %0d cycles, the sequence did not finish", cyc);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int          e0;
        int          run_len;
        int          pick;
        logic [31:0] lcg;
        rst_req = 1'b0;
        lcg = 32'h174e;
        // two full runs and one cut short, each followed by a quiet window
        run_len = init_len * (cs_cyc + 8) + gap_total();
        cyc_limit = 2 * (3 * run_len + 400) + 200;

        e0 = err_cnt;
        wait_for_done();
        check_count("words in first run", init_len, n_words);
        report_test("full sequence", e0);

        e0 = err_cnt;
        repeat (200) @(posedge clk);
        check_count("words after done", init_len, n_words);
        check_bit("done", 1'b1, done);
        check_bit("cs_n after done", 1'b1, cs_n);
        report_test("done hold", e0);

        e0 = err_cnt;
        lcg = lcg_next(lcg);
        lcg = lcg_next(lcg);
        pick = 1 + int'((lcg >> 8) % (init_len - 2));
        $display("mid-run reset during write %0d", pick);
        wait_for_done();
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        while (nrst) begin
            @(posedge clk);
        end
        check_bit("done in reset", 1'b0, done);
        while (!nrst) begin
            @(posedge clk);
        end
        // rerun from entry 0, then reset while the chosen write has wr_n low
        while (n_words < pick) begin
            @(posedge clk);
        end
        while (wr_n) begin
            @(posedge clk);
        end
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        while (nrst) begin
            @(posedge clk);
        end
        check_bit("cs_n in reset", 1'b1, cs_n);
        check_bit("wr_n in reset", 1'b1, wr_n);
        while (!nrst) begin
            @(posedge clk);
        end
        report_test("mid-run reset", e0);

        e0 = err_cnt;
        wait_for_done();
        check_count("words after restart", init_len, n_words);
        repeat (200) @(posedge clk);
        check_count("words after second done", init_len, n_words);
        check_bit("done", 1'b1, done);
        report_test("restart sequence", e0);

        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- files.f
design/disp_cmd_pkg.sv
design/disp_bus_pkg.sv
design/disp_init_rom.sv
design/disp_init_seq.sv
design/disp_bus_writer.sv
design/disp_init_top.sv
sim/disp_tb_clk.sv
sim/disp_init_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= disp_init_tb
FILELIST  ?= files.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# build, run, and fail unless the pass line is found
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
